/* Makefile */
VERILATOR ?= verilator
TOP       ?= flow_lookup_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard hdl/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/exact_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lookup_params.svh"

module exact_lookup import pkt_pkg::*, lookup_pkg::*; (
   input  wire            clk,
   input  wire            reset,
   input  wire pkt_data_t in_data,
   input  wire pkt_ctrl_t in_ctrl,
   input  wire            in_wr,
   rule_rd_if.engine      rd,
   output logic           hit,
   output logic           miss,
   output action_u        data,
   output logic           data_vld
);

   localparam rule_idx_t LAST_IDX = rule_idx_t'(`NUM_RULES - 1);

   typedef enum logic [1:0] {IDLE, REQ, WAIT} scan_state_t;

   scan_state_t state;
   rule_idx_t   idx;
   key_t        key;
   logic        key_empty;
   logic        match;
   logic        done;

   small_fifo #(.WIDTH(`KEY_WIDTH), .DEPTH_BITS(`FIFO_DEPTH_BITS)) key_fifo (
      .clk         (clk),
      .reset       (reset),
      .din         (in_data[16 +: `KEY_WIDTH]),
      .wr_en       (in_wr && in_ctrl == HDR_CTRL),
      .rd_en       (done),
      .dout        (key),
      .empty       (key_empty),
      .nearly_full ()
   );

   assign rd.req = (state == REQ);
   assign rd.idx = idx;

   assign match = rd.rdata.valid && rd.rdata.is_exact && rd.rdata.key == key;
   assign done  = (state == WAIT) && rd.rvalid && (match || idx == LAST_IDX);

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= IDLE;
         idx      <= '0;
         hit      <= 1'b0;
         miss     <= 1'b0;
         data_vld <= 1'b0;
      end else begin
         hit      <= done && match;
         miss     <= done && !match;
         data_vld <= done && match;
         case (state)
            IDLE: begin
               idx <= '0;
               if (!key_empty) state <= REQ;
            end
            REQ:  if (rd.gnt) state <= WAIT;
            WAIT: if (rd.rvalid) begin
               idx   <= idx + 1'b1;
               state <= done ? IDLE : REQ;
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (done)
         data <= match ? rd.rdata.action : '0;   // zero on a miss
   end

endmodule

`default_nettype wire

/* hdl/flow_lookup_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lookup_params.svh"

module flow_lookup_top import pkt_pkg::*, lookup_pkg::*; (
   input  wire                    clk,
   input  wire                    reset,
   input  wire pkt_data_t         in_data,
   input  wire pkt_ctrl_t         in_ctrl,
   input  wire                    in_wr,
   output logic                   in_rdy,
   output pkt_data_t              out_data,
   output pkt_ctrl_t              out_ctrl,
   output logic                   out_wr,
   input  wire                    out_rdy,
   input  wire                    cfg_wr,
   input  wire rule_idx_t         cfg_idx,
   input  wire rule_t             cfg_rule,
   input  wire port_idx_t         cnt_idx,
   output logic [`CNT_WIDTH-1:0]  cnt_value
);

   logic    exact_hit;
   logic    exact_miss;
   action_u exact_data;
   logic    exact_data_vld;
   logic    wild_hit;
   logic    wild_miss;
   action_u wild_data;
   logic    wild_data_vld;

   rule_rd_if exact_rd_if ();
   rule_rd_if wild_rd_if ();

   rule_table_arbiter rule_table_arbiter_inst (
      .clk (clk), .reset (reset), .cfg_wr (cfg_wr), .cfg_idx (cfg_idx),
      .cfg_rule (cfg_rule), .exact_rd (exact_rd_if), .wild_rd (wild_rd_if)
   );

   exact_lookup exact_lookup_inst (
      .clk (clk), .reset (reset), .in_data (in_data), .in_ctrl (in_ctrl), .in_wr (in_wr),
      .rd (exact_rd_if), .hit (exact_hit), .miss (exact_miss), .data (exact_data),
      .data_vld (exact_data_vld)
   );

   wildcard_lookup wildcard_lookup_inst (
      .clk (clk), .reset (reset), .in_data (in_data), .in_ctrl (in_ctrl), .in_wr (in_wr),
      .rd (wild_rd_if), .hit (wild_hit), .miss (wild_miss), .data (wild_data),
      .data_vld (wild_data_vld)
   );

   opl_processor opl_processor_inst (
      .clk (clk), .reset (reset),
      .in_data (in_data), .in_ctrl (in_ctrl), .in_wr (in_wr), .in_rdy (in_rdy),
      .exact_hit (exact_hit), .exact_miss (exact_miss), .exact_data (exact_data),
      .exact_data_vld (exact_data_vld),
      .wild_hit (wild_hit), .wild_miss (wild_miss), .wild_data (wild_data),
      .wild_data_vld (wild_data_vld),
      .out_data (out_data), .out_ctrl (out_ctrl), .out_wr (out_wr), .out_rdy (out_rdy),
      .cnt_idx (cnt_idx), .cnt_value (cnt_value)
   );

endmodule

`default_nettype wire

/* hdl/lookup_params.svh */
`ifndef LOOKUP_PARAMS_SVH
`define LOOKUP_PARAMS_SVH

// packet word widths
`define DATA_WIDTH       64
`define CTRL_WIDTH       8
`define KEY_WIDTH        16
`define NUM_PORTS        8

// rule table and queues
`define NUM_RULES        8
`define RULE_ADDR_W      3
`define FIFO_DEPTH_BITS  3
`define CNT_WIDTH        32

`endif

/* hdl/lookup_pkg.sv */
`default_nettype none

`include "lookup_params.svh"

package lookup_pkg;
   import pkt_pkg::*;

   localparam int ACTION_WIDTH = 32;

   typedef logic [`KEY_WIDTH-1:0] key_t;
   typedef logic [`RULE_ADDR_W-1:0] rule_idx_t;

   typedef struct packed {
      logic                            drop;
      logic [ACTION_WIDTH-2-`NUM_PORTS:0] reserved;
      port_mask_t                      out_ports;
   } fwd_action_t;

   // table keeps the raw word, processor reads the forwarding view
   typedef union packed {
      logic [ACTION_WIDTH-1:0] raw;
      fwd_action_t             fwd;
   } action_u;

   typedef struct packed {
      logic    valid;
      logic    is_exact;
      key_t    key;
      key_t    mask;        // wildcard care bits
      action_u action;
   } rule_t;

endpackage

`default_nettype wire

/* hdl/opl_processor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lookup_params.svh"

module opl_processor import pkt_pkg::*, lookup_pkg::*; (
   input  wire                    clk,
   input  wire                    reset,
   input  wire pkt_data_t         in_data,
   input  wire pkt_ctrl_t         in_ctrl,
   input  wire                    in_wr,
   output logic                   in_rdy,
   input  wire                    exact_hit,
   input  wire                    exact_miss,
   input  wire action_u           exact_data,
   input  wire                    exact_data_vld,
   input  wire                    wild_hit,
   input  wire                    wild_miss,
   input  wire action_u           wild_data,
   input  wire                    wild_data_vld,
   output pkt_data_t              out_data,
   output pkt_ctrl_t              out_ctrl,
   output logic                   out_wr,
   input  wire                    out_rdy,
   input  wire port_idx_t         cnt_idx,
   output logic [`CNT_WIDTH-1:0]  cnt_value
);

   localparam int PKT_W = `CTRL_WIDTH + `DATA_WIDTH;

   typedef enum logic {WAIT_FOR_LOOKUPS, WRITE_PACKET} state_t;

   state_t                state;
   state_t                state_nxt;
   logic [PKT_W-1:0]      fifo_dout;
   pkt_data_t             fifo_data;
   pkt_ctrl_t             fifo_ctrl;
   pkt_data_t             out_data_nxt;
   pkt_ctrl_t             out_ctrl_nxt;
   logic                  fifo_empty;
   logic                  fifo_nearly_full;
   logic                  fifo_rd;
   logic                  out_wr_nxt;
   logic                  prev_ctrl_zero;    // last word read had ctrl 0
   logic                  rd_results;
   logic                  results_rdy;
   logic                  exact_hit_q;
   logic                  wild_hit_q;
   logic                  exact_hit_empty;
   logic                  wild_hit_empty;
   logic                  exact_data_empty;
   logic                  wild_data_empty;
   action_u               exact_act;
   action_u               wild_act;
   port_idx_t             src_port;
   port_mask_t            win_ports;
   logic [`NUM_PORTS-1:0] pass_nxt;
   logic [`NUM_PORTS-1:0] pass_q;
   logic [`CNT_WIDTH-1:0] pkt_cnt [`NUM_PORTS];

   small_fifo #(.WIDTH(PKT_W), .DEPTH_BITS(`FIFO_DEPTH_BITS)) pkt_fifo (
      .clk (clk), .reset (reset), .din ({in_ctrl, in_data}), .wr_en (in_wr),
      .rd_en (fifo_rd), .dout (fifo_dout), .empty (fifo_empty),
      .nearly_full (fifo_nearly_full)
   );

   small_fifo #(.WIDTH($bits(port_idx_t)), .DEPTH_BITS(`FIFO_DEPTH_BITS)) src_port_fifo (
      .clk (clk), .reset (reset), .din (in_data[$bits(port_idx_t)-1:0]),
      .wr_en (in_wr && in_ctrl == HDR_CTRL), .rd_en (rd_results), .dout (src_port),
      .empty (), .nearly_full ()
   );

   small_fifo #(.WIDTH(1), .DEPTH_BITS(`FIFO_DEPTH_BITS)) exact_hit_fifo (
      .clk (clk), .reset (reset), .din (exact_hit), .wr_en (exact_hit | exact_miss),
      .rd_en (rd_results), .dout (exact_hit_q), .empty (exact_hit_empty), .nearly_full ()
   );

   small_fifo #(.WIDTH($bits(action_u)), .DEPTH_BITS(`FIFO_DEPTH_BITS)) exact_data_fifo (
      .clk (clk), .reset (reset), .din (exact_data), .wr_en (exact_data_vld | exact_miss),
      .rd_en (rd_results), .dout (exact_act), .empty (exact_data_empty), .nearly_full ()
   );

   small_fifo #(.WIDTH(1), .DEPTH_BITS(`FIFO_DEPTH_BITS)) wild_hit_fifo (
      .clk (clk), .reset (reset), .din (wild_hit), .wr_en (wild_hit | wild_miss),
      .rd_en (rd_results), .dout (wild_hit_q), .empty (wild_hit_empty), .nearly_full ()
   );

   small_fifo #(.WIDTH($bits(action_u)), .DEPTH_BITS(`FIFO_DEPTH_BITS)) wild_data_fifo (
      .clk (clk), .reset (reset), .din (wild_data), .wr_en (wild_data_vld | wild_miss),
      .rd_en (rd_results), .dout (wild_act), .empty (wild_data_empty), .nearly_full ()
   );

   assign {fifo_ctrl, fifo_data} = fifo_dout;
   assign in_rdy = !fifo_nearly_full;

   assign results_rdy = !exact_hit_empty && !exact_data_empty
                        && !wild_hit_empty && !wild_data_empty;

   // exact beats wildcard, no hit forwards nowhere
   assign win_ports = exact_hit_q ? exact_act.fwd.out_ports :
                      wild_hit_q  ? wild_act.fwd.out_ports  : '0;

   always_comb begin
      state_nxt    = state;
      out_wr_nxt   = 1'b0;
      out_data_nxt = fifo_data;
      out_ctrl_nxt = fifo_ctrl;
      fifo_rd      = 1'b0;
      rd_results   = 1'b0;
      pass_nxt     = '0;
      case (state)
         WAIT_FOR_LOOKUPS: begin
            if (results_rdy && out_rdy) begin
               rd_results         = 1'b1;
               fifo_rd            = 1'b1;
               out_wr_nxt         = 1'b1;
               out_data_nxt[15:8] = win_ports;   // header rewrite
               pass_nxt[src_port] = 1'b1;
               state_nxt          = WRITE_PACKET;
            end
         end
         WRITE_PACKET: begin
            if (out_rdy && !fifo_empty) begin
               fifo_rd    = 1'b1;
               out_wr_nxt = 1'b1;
               if (fifo_ctrl != '0 && prev_ctrl_zero)
                  state_nxt = WAIT_FOR_LOOKUPS;    // end of packet
            end
         end
         default: state_nxt = WAIT_FOR_LOOKUPS;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state          <= WAIT_FOR_LOOKUPS;
         out_wr         <= 1'b0;
         pass_q         <= '0;
         prev_ctrl_zero <= 1'b0;
      end else begin
         state  <= state_nxt;
         out_wr <= out_wr_nxt;
         pass_q <= pass_nxt;
         if (fifo_rd) prev_ctrl_zero <= (fifo_ctrl == '0);
      end
   end

   always_ff @(posedge clk) begin
      out_data <= out_data_nxt;
      out_ctrl <= out_ctrl_nxt;
   end

   // passed packets per source port
   always_ff @(posedge clk) begin
      for (int i = 0; i < `NUM_PORTS; i++) begin
         if (reset)
            pkt_cnt[i] <= '0;
         else if (pass_q[i])
            pkt_cnt[i] <= pkt_cnt[i] + 1'b1;
      end
   end

   assign cnt_value = pkt_cnt[cnt_idx];

endmodule

`default_nettype wire

/* hdl/pkt_pkg.sv */
`default_nettype none

`include "lookup_params.svh"

package pkt_pkg;

   typedef logic [`DATA_WIDTH-1:0] pkt_data_t;
   typedef logic [`CTRL_WIDTH-1:0] pkt_ctrl_t;

   typedef logic [$clog2(`NUM_PORTS)-1:0] port_idx_t;   // source port number
   typedef logic [`NUM_PORTS-1:0] port_mask_t;          // one bit per output port

   // control byte of the module header word
   localparam pkt_ctrl_t HDR_CTRL = 8'hFF;

endpackage

`default_nettype wire

/* hdl/rule_rd_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one lookup engine's path into the rule table
interface rule_rd_if import lookup_pkg::*; ();

   logic      req;      // held until gnt
   rule_idx_t idx;
   logic      gnt;
   rule_t     rdata;    // valid with rvalid, one cycle after gnt
   logic      rvalid;

   modport engine  (output req, output idx, input gnt, input rdata, input rvalid);
   modport arbiter (input req, input idx, output gnt, output rdata, output rvalid);

endinterface

`default_nettype wire

/* hdl/rule_table_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lookup_params.svh"

module rule_table_arbiter import lookup_pkg::*; (
   input  wire          clk,
   input  wire          reset,
   input  wire          cfg_wr,
   input  wire rule_idx_t cfg_idx,
   input  wire rule_t   cfg_rule,
   rule_rd_if.arbiter   exact_rd,
   rule_rd_if.arbiter   wild_rd
);

   rule_t     mem [`NUM_RULES];
   rule_t     rdata_q;
   rule_idx_t rd_idx;
   logic      exact_gnt;
   logic      wild_gnt;
   logic      exact_rvalid;
   logic      wild_rvalid;
   logic      last_exact;      // exact engine got the last contended grant

   // config write owns the table in its cycle, engines wait one cycle
   always_comb begin
      exact_gnt = 1'b0;
      wild_gnt  = 1'b0;
      if (!cfg_wr) begin
         if (exact_rd.req && wild_rd.req) begin
            exact_gnt = !last_exact;
            wild_gnt  = last_exact;
         end else begin
            exact_gnt = exact_rd.req;
            wild_gnt  = wild_rd.req;
         end
      end
   end

   assign rd_idx = exact_gnt ? exact_rd.idx : wild_rd.idx;

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `NUM_RULES; i++)
            mem[i].valid <= 1'b0;
      end else if (cfg_wr) begin
         mem[cfg_idx] <= cfg_rule;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         last_exact   <= 1'b0;    // exact goes first after reset
         exact_rvalid <= 1'b0;
         wild_rvalid  <= 1'b0;
      end else begin
         if (exact_gnt && wild_rd.req) last_exact <= 1'b1;
         if (wild_gnt && exact_rd.req) last_exact <= 1'b0;
         exact_rvalid <= exact_gnt;
         wild_rvalid  <= wild_gnt;
      end
   end

   always_ff @(posedge clk) begin
      rdata_q <= mem[rd_idx];
   end

   assign exact_rd.gnt    = exact_gnt;
   assign exact_rd.rdata  = rdata_q;
   assign exact_rd.rvalid = exact_rvalid;
   assign wild_rd.gnt     = wild_gnt;
   assign wild_rd.rdata   = rdata_q;
   assign wild_rd.rvalid  = wild_rvalid;

endmodule

`default_nettype wire

/* hdl/small_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

// fall-through fifo, head word visible on dout while not empty
module small_fifo #(
   parameter int WIDTH      = 8,
   parameter int DEPTH_BITS = 3
) (
   input  wire              clk,
   input  wire              reset,
   input  wire [WIDTH-1:0]  din,
   input  wire              wr_en,
   input  wire              rd_en,
   output logic [WIDTH-1:0] dout,
   output logic             empty,
   output logic             nearly_full
);

   localparam int DEPTH = 1 << DEPTH_BITS;

   logic [WIDTH-1:0]      mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;

   assign dout        = mem[rd_ptr];
   assign empty       = (count == '0);
   assign nearly_full = (count >= (DEPTH_BITS + 1)'(DEPTH - 1));   // one slot or less

   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_ptr] <= din;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;    // idle or push and pop together
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/wildcard_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lookup_params.svh"

module wildcard_lookup import pkt_pkg::*, lookup_pkg::*; (
   input  wire            clk,
   input  wire            reset,
   input  wire pkt_data_t in_data,
   input  wire pkt_ctrl_t in_ctrl,
   input  wire            in_wr,
   rule_rd_if.engine      rd,
   output logic           hit,
   output logic           miss,
   output action_u        data,
   output logic           data_vld
);

   localparam rule_idx_t LAST_IDX = rule_idx_t'(`NUM_RULES - 1);

   typedef enum logic [1:0] {IDLE, REQ, WAIT} scan_state_t;

   scan_state_t state;
   rule_idx_t   idx;
   key_t        key;
   key_t        diff;
   logic        key_empty;
   logic        match;
   logic        done;

   small_fifo #(.WIDTH(`KEY_WIDTH), .DEPTH_BITS(`FIFO_DEPTH_BITS)) key_fifo (
      .clk         (clk),
      .reset       (reset),
      .din         (in_data[16 +: `KEY_WIDTH]),
      .wr_en       (in_wr && in_ctrl == HDR_CTRL),
      .rd_en       (done),
      .dout        (key),
      .empty       (key_empty),
      .nearly_full ()
   );

   assign rd.req = (state == REQ);
   assign rd.idx = idx;

   // only bits under the mask have to agree
   assign diff  = (key ^ rd.rdata.key) & rd.rdata.mask;
   assign match = rd.rdata.valid && !rd.rdata.is_exact && diff == '0;
   assign done  = (state == WAIT) && rd.rvalid && (match || idx == LAST_IDX);

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= IDLE;
         idx      <= '0;
         hit      <= 1'b0;
         miss     <= 1'b0;
         data_vld <= 1'b0;
      end else begin
         hit      <= done && match;
         miss     <= done && !match;
         data_vld <= done && match;
         case (state)
            IDLE: begin
               idx <= '0;     // scan always restarts at rule 0
               if (!key_empty) state <= REQ;
            end
            REQ:  if (rd.gnt) state <= WAIT;
            WAIT: if (rd.rvalid) begin
               idx   <= idx + 1'b1;
               state <= done ? IDLE : REQ;
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (done)
         data <= match ? rd.rdata.action : '0;
   end

endmodule

`default_nettype wire

/* project.f */
+incdir+hdl
hdl/pkt_pkg.sv
hdl/lookup_pkg.sv
hdl/rule_rd_if.sv
hdl/small_fifo.sv
hdl/rule_table_arbiter.sv
hdl/exact_lookup.sv
hdl/wildcard_lookup.sv
hdl/opl_processor.sv
hdl/flow_lookup_top.sv
testbench/flow_lookup_tb.sv

/* testbench/flow_lookup_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lookup_params.svh"

module flow_lookup_tb import pkt_pkg::*, lookup_pkg::*; ();

   localparam int PKT_W = `CTRL_WIDTH + `DATA_WIDTH;

   logic                  clk;
   logic                  reset;
   pkt_data_t             in_data;
   pkt_ctrl_t             in_ctrl;
   logic                  in_wr;
   logic                  in_rdy;
   pkt_data_t             out_data;
   pkt_ctrl_t             out_ctrl;
   logic                  out_wr;
   logic                  out_rdy;
   logic                  cfg_wr;
   rule_idx_t             cfg_idx;
   rule_t                 cfg_rule;
   port_idx_t             cnt_idx;
   logic [`CNT_WIDTH-1:0] cnt_value;

   rule_t             rules_ref [`NUM_RULES];   // copy of what was written to the table
   logic [PKT_W-1:0]  expected_q [$];
   logic [PKT_W-1:0]  exp_word;
   int                sent_per_port [`NUM_PORTS];
   int                words_sent = 0;
   int                words_checked = 0;
   int                cycles = 0;
   logic              random_rdy;
   logic              rdy_prev;                 // out_rdy in the cycle before

   flow_lookup_top flow_lookup_top_inst (
      .clk (clk), .reset (reset),
      .in_data (in_data), .in_ctrl (in_ctrl), .in_wr (in_wr), .in_rdy (in_rdy),
      .out_data (out_data), .out_ctrl (out_ctrl), .out_wr (out_wr), .out_rdy (out_rdy),
      .cfg_wr (cfg_wr), .cfg_idx (cfg_idx), .cfg_rule (cfg_rule),
      .cnt_idx (cnt_idx), .cnt_value (cnt_value)
   );

   always #20 clk = ~clk;

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_word(input string name, input pkt_data_t got, input pkt_data_t exp);
      if (got !== exp)
         stop_on_error($sformatf("ERROR at %0d ns: %s is %h, expected %h",
                                 $time, name, got, exp));
   endtask

   task automatic check_ctrl(input string name, input pkt_ctrl_t got, input pkt_ctrl_t exp);
      if (got !== exp)
         stop_on_error($sformatf("ERROR at %0d ns: %s is %h, expected %h",
                                 $time, name, got, exp));
   endtask

   task automatic check_count(input string name, input logic [`CNT_WIDTH-1:0] got,
                              input logic [`CNT_WIDTH-1:0] exp);
      if (got !== exp)
         stop_on_error($sformatf("ERROR at %0d ns: %s is %0d, expected %0d",
                                 $time, name, got, exp));
   endtask

   // exact rules before wildcard rules, and the lowest index within each group
   function automatic port_mask_t expected_ports(input key_t key);
      port_mask_t ports;
      logic       found;
      ports = '0;   // no matching rule means no ports
      found = 1'b0;
      for (int i = 0; i < `NUM_RULES; i++) begin
         if (!found && rules_ref[i].valid && rules_ref[i].is_exact
             && rules_ref[i].key == key) begin
            ports = rules_ref[i].action.fwd.out_ports;
            found = 1'b1;
         end
      end
      for (int i = 0; i < `NUM_RULES; i++) begin
         if (!found && rules_ref[i].valid && !rules_ref[i].is_exact
             && (key & rules_ref[i].mask) == (rules_ref[i].key & rules_ref[i].mask)) begin
            ports = rules_ref[i].action.fwd.out_ports;
            found = 1'b1;
         end
      end
      return ports;
   endfunction

   function automatic key_t pick_key();
      case ($urandom % 9)
         0: return 16'h1234;
         1: return 16'h12ff;
         2: return 16'h1235;
         3: return 16'habcd;
         4: return 16'ha123;
         5: return 16'h5555;
         6: return 16'h7766;
         default: return key_t'($urandom);
      endcase
   endfunction

   task automatic write_rule(input rule_idx_t idx, input logic valid, input logic is_exact,
                             input key_t key, input key_t mask, input port_mask_t ports);
      rule_t r;
      r.valid                = valid;
      r.is_exact             = is_exact;
      r.key                  = key;
      r.mask                 = mask;
      r.action.fwd.drop      = 1'b0;
      r.action.fwd.reserved  = 23'($urandom);   // random filler that must stay out of the ports
      r.action.fwd.out_ports = ports;
      @(posedge clk);
      #2;
      cfg_wr   = 1'b1;
      cfg_idx  = idx;
      cfg_rule = r;
      @(posedge clk);
      #2;
      cfg_wr = 1'b0;
      rules_ref[idx] = r;
   endtask

   task automatic send_word(input pkt_ctrl_t ctrl, input pkt_data_t data);
      @(posedge clk);
      #2;
      while (!in_rdy) begin   // hold off while the fifo is nearly full
         in_wr = 1'b0;
         @(posedge clk);
         #2;
      end
      in_wr   = 1'b1;
      in_data = data;
      in_ctrl = ctrl;
      words_sent++;
   endtask

   task automatic end_burst();
      @(posedge clk);
      #2;
      in_wr = 1'b0;
   endtask

   // header followed by n_data words with ctrl 0 except a nonzero ctrl on the last one
   task automatic send_packet(input port_idx_t port, input key_t key, input int n_data);
      pkt_data_t hdr;
      pkt_data_t hdr_exp;
      pkt_data_t word;
      pkt_ctrl_t ctrl;
      hdr        = {$urandom, $urandom};
      hdr[31:16] = key;
      hdr[7:0]   = 8'(port);
      hdr_exp    = hdr;
      hdr_exp[15:8] = expected_ports(key);
      expected_q.push_back({HDR_CTRL, hdr_exp});
      send_word(HDR_CTRL, hdr);
      for (int i = 0; i < n_data; i++) begin
         word = {$urandom, $urandom};
         ctrl = (i == n_data - 1) ? pkt_ctrl_t'(1 << ($urandom % 8)) : '0;
         expected_q.push_back({ctrl, word});
         send_word(ctrl, word);
      end
      sent_per_port[port]++;
   endtask

   task automatic wait_drained();
      while (expected_q.size() != 0)
         @(posedge clk);
      repeat (4) @(posedge clk);   // counters lag the header by a cycle
   endtask

   task automatic check_counters();
      for (int p = 0; p < `NUM_PORTS; p++) begin
         @(posedge clk);
         #2;
         cnt_idx = port_idx_t'(p);
         @(negedge clk);
         check_count($sformatf("cnt_value[%0d]", p), cnt_value, `CNT_WIDTH'(sent_per_port[p]));
      end
   endtask

   // receiver ready 70 percent of the cycles when randomized
   always @(posedge clk) begin
      #2;
      if (random_rdy)
         out_rdy = (($urandom % 10) < 7);
      else
         out_rdy = 1'b1;
   end

   // compare every word the DUT sends
   always @(negedge clk) begin
      if (!reset && out_wr) begin
         if (!rdy_prev)
            stop_on_error($sformatf("word sent at %0d ns after a cycle with out_rdy low",
                                    $time));
         if (expected_q.size() == 0) begin
            stop_on_error($sformatf("output word %h seen at %0d ns with none expected",
                                    out_data, $time));
         end else begin
            exp_word = expected_q.pop_front();
            check_ctrl("out_ctrl", out_ctrl, exp_word[PKT_W-1 -: `CTRL_WIDTH]);
            check_word("out_data", out_data, exp_word[`DATA_WIDTH-1:0]);
            words_checked++;
         end
      end
      rdy_prev = out_rdy;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > 40 * words_sent + 2000)
         stop_on_error($sformatf("timeout after %0d cycles, %0d of %0d words checked",
                                 cycles, words_checked, words_sent));
   end

   initial begin
      void'($urandom(57));
      clk        = 1'b0;
      reset      = 1'b1;
      in_data    = '0;
      in_ctrl    = '0;
      in_wr      = 1'b0;
      out_rdy    = 1'b1;
      cfg_wr     = 1'b0;
      cfg_idx    = '0;
      cfg_rule   = '0;
      cnt_idx    = '0;
      random_rdy = 1'b0;
      rdy_prev   = 1'b1;
      for (int p = 0; p < `NUM_PORTS; p++)
         sent_per_port[p] = 0;
      for (int i = 0; i < `NUM_RULES; i++)
         rules_ref[i] = '0;

      repeat (8) @(posedge clk);
      #2;
      reset = 1'b0;
      @(negedge clk);
      if (!in_rdy)
         stop_on_error("in_rdy is low after reset");
      check_counters();

      // empty table so headers only lose bits 15:8
      for (int n = 0; n < 6; n++)
         send_packet(port_idx_t'($urandom), pick_key(), 2 + ($urandom % 5));
      end_burst();
      wait_drained();

      write_rule(3'd0, 1'b1, 1'b0, 16'h1200, 16'hff00, 8'h0c);
      write_rule(3'd1, 1'b1, 1'b0, 16'h1230, 16'hfff0, 8'h30);   // shadowed by rule 0
      write_rule(3'd2, 1'b1, 1'b1, 16'h1234, 16'hffff, 8'h81);
      write_rule(3'd3, 1'b0, 1'b1, 16'h5555, 16'hffff, 8'h02);   // not valid
      write_rule(3'd4, 1'b1, 1'b1, 16'habcd, 16'hffff, 8'h40);
      write_rule(3'd5, 1'b1, 1'b0, 16'ha000, 16'hf000, 8'h11);
      write_rule(3'd6, 1'b1, 1'b0, 16'h0066, 16'h00ff, 8'h22);
      write_rule(3'd7, 1'b0, 1'b0, 16'h5555, 16'hffff, 8'h04);   // not valid

      // directed keys for each rule case
      send_packet(3'd1, 16'habcd, 2);
      send_packet(3'd2, 16'h1234, 3);
      send_packet(3'd3, 16'h12ff, 2);
      send_packet(3'd4, 16'h1235, 4);
      send_packet(3'd5, 16'h5555, 2);
      send_packet(3'd6, 16'h7766, 3);
      send_packet(3'd7, 16'ha123, 2);
      end_burst();
      wait_drained();

      // random traffic with back pressure
      random_rdy = 1'b1;
      for (int n = 0; n < 40; n++) begin
         send_packet(port_idx_t'($urandom), pick_key(), 2 + ($urandom % 5));
         if ($urandom % 4 == 0)
            end_burst();   // short gap now and then
      end
      end_burst();
      wait_drained();
      random_rdy = 1'b0;
      check_counters();

      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire
